// File: flist.f
logic/alu_isa_pkg.sv
logic/alu_result_pkg.sv
logic/alu_op_if.sv
logic/alu_stage_reg.sv
logic/alu_decode.sv
logic/alu_mul_pipe.sv
logic/alu_exec.sv
logic/alu_writeback.sv
logic/alu_top.sv
dv/alu_properties.sv
dv/alu_tb.sv

// File: dv/alu_tb.sv
/*
 * Self-checking testbench for the execute lane. Random operations from a
 * fixed seed are issued, predicted by a reference model and scoreboarded.
 */
`timescale 1ns/1ps

module alu_tb
	import alu_isa_pkg::*;
	import alu_result_pkg::*;
();

	localparam int N_ARITH    = 60;
	localparam int N_CMP      = 60;
	localparam int N_SHMUL    = 60;
	localparam int N_FAULT    = 48;
	localparam int N_GAP      = 40;
	localparam int N_OPS      = N_ARITH + N_CMP + N_SHMUL + N_FAULT + N_GAP;
	// Covers reset, gaps and pipeline drain
	localparam int MAX_CYCLES = N_OPS * 2 + 100;

	logic             clk;
	logic             rst;
	logic             issue_valid;
	instr_t           instr;
	logic [XLEN-1:0]  a;
	logic [XLEN-1:0]  b;
	logic [XLEN-1:0]  c;
	logic [XLEN-1:0]  t;
	logic [TAG_W-1:0] tag;
	logic             result_valid;
	logic [XLEN-1:0]  result;
	logic [TAG_W-1:0] result_tag;
	cause_e           cause;

	integer           seed;
	int               errors;
	int               other_errors;
	int               cycle_count;
	logic [TAG_W-1:0] next_tag;
	// Scoreboard with one entry per issued operation
	logic [XLEN-1:0]  exp_val_q[$];
	logic [TAG_W-1:0] exp_tag_q[$];
	logic [7:0]       exp_cause_q[$];

	alu_top DUT (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.instr       (instr),
		.a           (a),
		.b           (b),
		.c           (c),
		.t           (t),
		.tag         (tag),
		.result_valid(result_valid),
		.result      (result),
		.result_tag  (result_tag),
		.cause       (cause)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ======================================================================
	// Random helpers
	// ======================================================================
	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	function automatic int unsigned pick(input int unsigned n);
		logic [31:0] r;
		r = $random(seed);
		return r % n;
	endfunction

	// Sign boundaries and small values show up often
	function automatic logic [XLEN-1:0] edge_val();
		case (pick(6))
			0: return '0;
			1: return 32'h8000_0000;
			2: return 32'h7fff_ffff;
			3: return 32'hffff_ffff;
			4: return 32'h1;
			default: return rnd();
		endcase
	endfunction

	function automatic instr_t make_instr(input logic [4:0] opc, input logic [4:0] fn,
		input logic [2:0] o2, input logic isel, input logic [5:0] sh,
		input logic [IMM_W-1:0] im);
		return instr_t'({opc, fn, o2, isel, sh, im});
	endfunction

	function automatic logic less(input logic sgn, input logic [XLEN-1:0] x,
		input logic [XLEN-1:0] y);
		if (sgn)
			return $signed(x) < $signed(y);
		return x < y;
	endfunction

	// ======================================================================
	// Reference model returning {cause, value}
	// ======================================================================
	function automatic logic [XLEN+7:0] model_op(input instr_t ins,
		input logic [XLEN-1:0] oa, input logic [XLEN-1:0] ob,
		input logic [XLEN-1:0] oc, input logic [XLEN-1:0] ot);
		logic [XLEN-1:0]   cv;
		logic [XLEN-1:0]   lv;
		logic [XLEN-1:0]   v;
		logic [4:0]        sh;
		logic [2*XLEN-1:0] prod;
		logic [7:0]        cs;
		logic              bad;
		logic              lo_ok;
		logic              hi_ok;
		// Immediate replaces c when selected and ADDI always adds it
		cv = (ins.imm_sel || ins.opcode == OP_ADDI) ?
			{{(XLEN-IMM_W){ins.imm[IMM_W-1]}}, ins.imm} : oc;
		sh = ins.imm_sel ? ins.shamt[4:0] : oc[4:0];
		v = '0;
		cs = CAUSE_NONE;
		bad = 1'b0;
		case (ins.opcode)
			OP_R2:
				case (ins.func)
					FN_ADD, FN_AND, FN_OR, FN_EOR:
					begin
						if (ins.func == FN_ADD)
							lv = oa + ob;
						else if (ins.func == FN_AND)
							lv = oa & ob;
						else if (ins.func == FN_OR)
							lv = oa | ob;
						else
							lv = oa ^ ob;
						bad = ins.op2 > ((ins.func == FN_ADD) ? 3 : 2);
						case (ins.op2)
							3'd0: v = lv & cv;
							3'd1: v = lv | cv;
							3'd2: v = lv ^ cv;
							default: v = lv + cv;
						endcase
					end
					FN_SUB:  v = oa - ob - cv;
					FN_SEQ:  v = (oa == ob) ? cv : ot;
					FN_SLT:  v = less(1'b1, oa, ob) ? cv : ot;
					FN_SLTU: v = less(1'b0, oa, ob) ? cv : ot;
					FN_MIN, FN_MINU:
					begin
						v = less(ins.func == FN_MIN, ob, oa) ? ob : oa;
						v = less(ins.func == FN_MIN, cv, v) ? cv : v;
					end
					FN_MAX, FN_MAXU:
					begin
						v = less(ins.func == FN_MAX, oa, ob) ? ob : oa;
						v = less(ins.func == FN_MAX, v, cv) ? cv : v;
					end
					default: bad = 1'b1;
				endcase
			OP_ADDI: v = oa + cv;
			OP_SHIFT:
				case (ins.func)
					5'd0: v = oa << sh;
					5'd1: v = oa >> sh;
					5'd2: v = $signed(oa) >>> sh;
					default: bad = 1'b1;
				endcase
			OP_MUL:
			begin
				bad = ins.func > 5'd3;
				// Functions 1 and 3 are unsigned while 2 and 3 take the high half
				if (ins.func[0])
					prod = {{XLEN{1'b0}}, oa} * {{XLEN{1'b0}}, ob};
				else
					prod = {{XLEN{oa[XLEN-1]}}, oa} * {{XLEN{ob[XLEN-1]}}, ob};
				v = ins.func[1] ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
			end
			OP_CHK:
			begin
				bad = ins.func > 5'd3;
				lo_ok = ins.func[1] ? (oa > ob) : (oa >= ob);
				hi_ok = ins.func[0] ? (oa <= cv) : (oa < cv);
				if (!(lo_ok && hi_ok))
					cs = ins.imm[7:0];
			end
			OP_NOP: v = ot;
			default: bad = 1'b1;
		endcase
		if (bad)
		begin
			v = '0;
			cs = CAUSE_UNIMP;
		end
		return {cs, v};
	endfunction

	// ======================================================================
	// Driving and checking
	// ======================================================================
	task automatic issue_op(input instr_t ins, input logic [XLEN-1:0] oa,
		input logic [XLEN-1:0] ob, input logic [XLEN-1:0] oc, input logic [XLEN-1:0] ot);
		logic [XLEN+7:0] e;
		e = model_op(ins, oa, ob, oc, ot);
		@(posedge clk);
		issue_valid <= 1'b1;
		instr       <= ins;
		a           <= oa;
		b           <= ob;
		c           <= oc;
		t           <= ot;
		tag         <= next_tag;
		exp_val_q.push_back(e[XLEN-1:0]);
		exp_cause_q.push_back(e[XLEN+7:XLEN]);
		exp_tag_q.push_back(next_tag);
		next_tag = next_tag + 1'b1;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		issue_valid <= 1'b0;
	endtask

	task automatic check_equal(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Outputs are sampled mid-cycle where they are stable
	always @(negedge clk)
	begin
		if (result_valid === 1'b1)
		begin
			if (exp_val_q.size() == 0)
			begin
				$display("Result strobe at %0t ns with no operation outstanding", $time);
				other_errors++;
			end
			else
			begin
				check_equal(result, exp_val_q.pop_front(), "result value");
				check_equal(result_tag, exp_tag_q.pop_front(), "result tag");
				check_equal(cause, exp_cause_q.pop_front(), "cause");
			end
		end
	end

	// Run limit
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Run did not finish within %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ======================================================================
	// Test phases
	// ======================================================================
	task automatic run_arith();
		logic [IMM_W-1:0] im;
		logic [4:0]       fn;
		logic [2:0]       o2;
		int               i;
		for (i = 0; i < N_ARITH; i++)
		begin
			im = rnd();
			fn = pick(5);
			o2 = (fn == FN_ADD) ? pick(4) : pick(3);
			if (pick(5) == 0)
			begin
				// Mostly negative immediates
				im[IMM_W-1] = pick(4) != 0;
				issue_op(make_instr(OP_ADDI, 5'd0, 3'd0, 1'b0, 6'd0, im),
					rnd(), rnd(), rnd(), rnd());
			end
			else
				issue_op(make_instr(OP_R2, fn, o2, pick(4) == 0, 6'd0, im),
					rnd(), rnd(), rnd(), rnd());
		end
	endtask

	task automatic run_compare();
		logic [XLEN-1:0] oa;
		logic [XLEN-1:0] ob;
		logic [XLEN-1:0] oc;
		int              i;
		for (i = 0; i < N_CMP; i++)
		begin
			oa = edge_val();
			ob = pick(2) ? oa : edge_val();
			oc = (pick(3) == 0) ? oa : edge_val();
			issue_op(make_instr(OP_R2, FN_SEQ + pick(7), 3'd0, 1'b0, 6'd0, 12'd0),
				oa, ob, oc, rnd());
		end
	endtask

	// Back to back so three operations are in flight
	task automatic run_shift_mul();
		int i;
		for (i = 0; i < N_SHMUL; i++)
		begin
			if (pick(2))
				issue_op(make_instr(OP_SHIFT, pick(3), 3'd0, pick(2), rnd(), 12'd0),
					edge_val(), rnd(), rnd(), rnd());
			else
				issue_op(make_instr(OP_MUL, pick(4), 3'd0, 1'b0, 6'd0, 12'd0),
					edge_val(), edge_val(), rnd(), rnd());
		end
	endtask

	task automatic run_faults();
		logic [XLEN-1:0] lo;
		logic [XLEN-1:0] hi;
		logic [XLEN-1:0] oa;
		logic [7:0]      code;
		int              form;
		int              i;
		// Each range form with a placed at and around both bounds
		for (form = 0; form < 4; form++)
		begin
			for (i = 0; i < 8; i++)
			begin
				lo = rnd() >> 1;
				hi = lo + pick(64) + 1;
				case (pick(6))
					0: oa = lo - 1;
					1: oa = lo;
					2: oa = lo + 1;
					3: oa = hi - 1;
					4: oa = hi;
					default: oa = hi + 1;
				endcase
				code = rnd();
				issue_op(make_instr(OP_CHK, form, 3'd0, 1'b0, 6'd0, {4'h0, code}),
					oa, lo, hi, rnd());
			end
		end
		// Illegal opcodes, functions and combiners
		for (i = 0; i < N_FAULT - 32; i++)
		begin
			case (pick(4))
				0: issue_op(make_instr(5'd6 + pick(26), pick(32), 3'd0, 1'b0, 6'd0, 12'd0),
					rnd(), rnd(), rnd(), rnd());
				1: issue_op(make_instr(OP_R2, 5'd12 + pick(20), 3'd0, 1'b0, 6'd0, 12'd0),
					rnd(), rnd(), rnd(), rnd());
				2: issue_op(make_instr(OP_R2, FN_AND + pick(3), 3'd3 + pick(5), 1'b0, 6'd0,
					12'd0), rnd(), rnd(), rnd(), rnd());
				default: issue_op(make_instr(pick(2) ? OP_SHIFT : OP_MUL, 5'd4 + pick(28),
					3'd0, 1'b0, 6'd0, 12'd0), rnd(), rnd(), rnd(), rnd());
			endcase
		end
	endtask

	// Fully random operations with idle gaps in between
	task automatic run_gaps();
		int i;
		for (i = 0; i < N_GAP; i++)
		begin
			issue_op(make_instr(pick(7), pick(13), pick(8), pick(2), rnd(), rnd()),
				edge_val(), edge_val(), edge_val(), rnd());
			if (pick(2))
				idle_cycle();
		end
		idle_cycle();
	endtask

	initial
	begin
		seed         = 32'h2de1_f4a1;
		errors       = 0;
		other_errors = 0;
		cycle_count  = 0;
		next_tag     = '0;
		rst          = 1'b1;
		issue_valid  = 1'b0;
		instr        = '0;
		a            = '0;
		b            = '0;
		c            = '0;
		t            = '0;
		tag          = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		// Quiet cycles right after reset
		repeat (4) idle_cycle();
		run_arith();
		run_compare();
		run_shift_mul();
		run_faults();
		run_gaps();
		// Last result is due three cycles after the final issue
		repeat (5) @(posedge clk);
		if (exp_val_q.size() != 0)
		begin
			$display("%0d operations never produced a result", exp_val_q.size());
			other_errors++;
		end
		$display("Error counts: %0d check failures, %0d other errors", errors, other_errors);
		if (errors == 0 && other_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: dv/alu_properties.sv
/*
 * Latency and reset assertions for the execute lane.
 * Bound into alu_top by the statement at the end of this file.
 */
`timescale 1ns/1ps

module alu_properties (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input logic result_valid
);

	// Every issue retires exactly three cycles later
	a_latency: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> ##3 result_valid)
		else $error("Issue strobe was not followed by result_valid three cycles later");

	// No result without a matching issue
	a_no_spurious: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> $past(issue_valid, 3))
		else $error("result_valid high without an issue three cycles earlier");

	// Reset holds the strobe low
	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !result_valid)
		else $error("result_valid high while reset was asserted");

endmodule

bind alu_top alu_properties u_props (
	.clk         (clk),
	.rst         (rst),
	.issue_valid (issue_valid),
	.result_valid(result_valid)
);

// File: logic/alu_top.sv
/*
 * Three-stage integer execute lane. Issue one operation per strobe,
 * the result appears three cycles later, in issue order.
 */
`timescale 1ns/1ps

module alu_top
	import alu_isa_pkg::*;
	import alu_result_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             issue_valid,
	input  instr_t           instr,
	input  logic [XLEN-1:0]  a,
	input  logic [XLEN-1:0]  b,
	input  logic [XLEN-1:0]  c,
	input  logic [XLEN-1:0]  t,
	input  logic [TAG_W-1:0] tag,
	output logic             result_valid,
	output logic [XLEN-1:0]  result,
	output logic [TAG_W-1:0] result_tag,
	output cause_e           cause
);

	// Exec to writeback
	logic              res_valid;
	exec_res_t         res;
	logic [2*XLEN-1:0] product;

	// Decoded operation bus
	alu_op_if op_bus ();

	alu_decode u_decode (
		.clk        (clk),
		.rst        (rst),
		.issue_valid(issue_valid),
		.instr      (instr),
		.a          (a),
		.b          (b),
		.c          (c),
		.t          (t),
		.tag        (tag),
		.op         (op_bus)
	);

	// Runs beside exec, no valid of its own
	alu_mul_pipe u_mul (
		.clk    (clk),
		.op     (op_bus),
		.product(product)
	);

	alu_exec u_exec (
		.clk      (clk),
		.rst      (rst),
		.op       (op_bus),
		.res_valid(res_valid),
		.res      (res)
	);

	alu_writeback u_wb (
		.clk         (clk),
		.rst         (rst),
		.res_valid   (res_valid),
		.res         (res),
		.product     (product),
		.result_valid(result_valid),
		.result      (result),
		.result_tag  (result_tag),
		.cause       (cause)
	);

endmodule

// File: logic/alu_writeback.sv
/*
 * Writeback stage. Merges the multiplier product with the exec result
 * and drives the one-cycle result strobe and its data.
 */
`timescale 1ns/1ps

module alu_writeback
	import alu_isa_pkg::*;
	import alu_result_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              res_valid,
	input  exec_res_t         res,
	input  logic [2*XLEN-1:0] product,
	output logic              result_valid,
	output logic [XLEN-1:0]   result,
	output logic [TAG_W-1:0]  result_tag,
	output cause_e            cause
);

	logic [XLEN-1:0] value_d;

	// Product half for multiplies, exec value otherwise
	always_comb
	begin
		if (!res.is_mul)
			value_d = res.value;
		else if (res.mul_high)
			value_d = product[2*XLEN-1:XLEN];
		else
			value_d = product[XLEN-1:0];
	end

	// Strobe
	always_ff @(posedge clk)
	begin
		if (rst)
			result_valid <= 1'b0;
		else
			result_valid <= res_valid;
	end

	// Data follows the exec register every cycle
	always_ff @(posedge clk)
	begin
		result     <= value_d;
		result_tag <= res.tag;
		cause      <= res.cause;
	end

endmodule

// File: logic/alu_exec.sv
/*
 * Execute stage. Forms every single-cycle result and bounds-check fault
 * from the decoded operation and registers it for writeback.
 */
`timescale 1ns/1ps

module alu_exec
	import alu_isa_pkg::*;
	import alu_result_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	alu_op_if.consumer op,
	output logic       res_valid,
	output exec_res_t  res
);

	dec_op_t         d;
	logic [XLEN-1:0] lop;
	logic            chk_in;
	exec_res_t       res_d;

	// Pick the min or max of three, signed or unsigned
	function automatic logic [XLEN-1:0] sel3(
		input logic            sgn,
		input logic            is_max,
		input logic [XLEN-1:0] x,
		input logic [XLEN-1:0] y,
		input logic [XLEN-1:0] z
	);
		logic signed [XLEN:0] be;
		logic signed [XLEN:0] ye;
		logic signed [XLEN:0] ze;
		logic [XLEN-1:0]      best;
		be   = {sgn & x[XLEN-1], x};
		ye   = {sgn & y[XLEN-1], y};
		ze   = {sgn & z[XLEN-1], z};
		best = x;
		if (is_max ? (ye > be) : (ye < be))
		begin
			be   = ye;
			best = y;
		end
		if (is_max ? (ze > be) : (ze < be))
			best = z;
		return best;
	endfunction

	assign d = op.data;

	// First half of the three-input logic forms
	always_comb
	begin
		case (d.func)
			FN_AND:  lop = d.a & d.b;
			FN_OR:   lop = d.a | d.b;
			FN_EOR:  lop = d.a ^ d.b;
			default: lop = d.a + d.b;
		endcase
	end

	// Range test for OP_CHK, compares are unsigned
	always_comb
	begin
		case (d.func)
			CHK_GE_LT: chk_in = (d.a >= d.b) && (d.a < d.c);
			CHK_GE_LE: chk_in = (d.a >= d.b) && (d.a <= d.c);
			CHK_GT_LT: chk_in = (d.a > d.b) && (d.a < d.c);
			CHK_GT_LE: chk_in = (d.a > d.b) && (d.a <= d.c);
			default:   chk_in = 1'b1;
		endcase
	end

	// ======================================================================
	// Result select
	// ======================================================================
	always_comb
	begin
		res_d.value    = '0;
		res_d.cause    = CAUSE_NONE;
		res_d.tag      = d.tag;
		res_d.is_mul   = d.is_mul;
		res_d.mul_high = (d.func == FN_MULH) || (d.func == FN_MULHU);
		case (d.opcode)
			OP_R2:
				case (d.func)
					FN_ADD, FN_AND, FN_OR, FN_EOR:
						case (d.op2)
							OP2_AND: res_d.value = lop & d.c;
							OP2_OR:  res_d.value = lop | d.c;
							OP2_EOR: res_d.value = lop ^ d.c;
							OP2_ADD: res_d.value = lop + d.c;
							default: res_d.value = '0;
						endcase
					FN_SUB:  res_d.value = d.a - d.b - d.c;
					// Set forms return c on true, old target otherwise
					FN_SEQ:  res_d.value = (d.a == d.b) ? d.c : d.t;
					FN_SLT:  res_d.value = ($signed(d.a) < $signed(d.b)) ? d.c : d.t;
					FN_SLTU: res_d.value = (d.a < d.b) ? d.c : d.t;
					FN_MIN:  res_d.value = sel3(1'b1, 1'b0, d.a, d.b, d.c);
					FN_MAX:  res_d.value = sel3(1'b1, 1'b1, d.a, d.b, d.c);
					FN_MINU: res_d.value = sel3(1'b0, 1'b0, d.a, d.b, d.c);
					FN_MAXU: res_d.value = sel3(1'b0, 1'b1, d.a, d.b, d.c);
					default: res_d.value = '0;
				endcase
			// c already holds the immediate
			OP_ADDI:
				res_d.value = d.a + d.c;
			OP_SHIFT:
				case (d.func)
					FN_ASL:  res_d.value = d.a << d.shamt;
					FN_LSR:  res_d.value = d.a >> d.shamt;
					FN_ASR:  res_d.value = $signed(d.a) >>> d.shamt;
					default: res_d.value = '0;
				endcase
			// Value stays zero, cause only on a miss
			OP_CHK:
				if (!chk_in)
					res_d.cause = cause_e'(d.chk_code);
			OP_NOP:
				res_d.value = d.t;
			default:
				res_d.value = '0;
		endcase
		// Illegal encodings override everything
		if (d.is_unimp)
		begin
			res_d.value  = '0;
			res_d.cause  = CAUSE_UNIMP;
			res_d.is_mul = 1'b0;
		end
	end

	alu_stage_reg #(
		.payload_t(exec_res_t)
	) u_exec_reg (
		.clk      (clk),
		.rst      (rst),
		.in_valid (op.valid),
		.in_data  (res_d),
		.out_valid(res_valid),
		.out_data (res)
	);

endmodule

// File: logic/alu_mul_pipe.sv
/*
 * Free-running multiplier beside the execute stage. Partial products are
 * registered with the exec result, the 64-bit product is summed after it.
 */
`timescale 1ns/1ps

module alu_mul_pipe
	import alu_isa_pkg::*;
	import alu_result_pkg::*;
(
	input  logic              clk,
	alu_op_if.consumer        op,
	output logic [2*XLEN-1:0] product
);

	localparam int HALF = XLEN / 2;
	// 33-bit operand by 17-bit slice
	localparam int PP_W = (XLEN + 1) + (HALF + 1);

	mul_sel_e               sel;
	logic                   sgn;
	logic signed [XLEN:0]   ax;
	logic signed [XLEN:0]   bx;
	logic signed [PP_W-1:0] pp_lo_d;
	logic signed [PP_W-1:0] pp_hi_d;
	logic signed [PP_W-1:0] pp_lo_q;
	logic signed [PP_W-1:0] pp_hi_q;

	// Signed or unsigned from the function field
	always_comb
	begin
		case (op.data.func)
			FN_MULU, FN_MULHU:
				sel = MUL_UNSIGNED;
			FN_MUL, FN_MULH:
				sel = MUL_SIGNED;
			default:
				sel = MUL_SIGNED;
		endcase
	end

	assign sgn = (sel == MUL_SIGNED);

	// One extra bit makes both forms a signed multiply
	assign ax = {sgn & op.data.a[XLEN-1], op.data.a};
	assign bx = {sgn & op.data.b[XLEN-1], op.data.b};

	// ======================================================================
	// Partial products
	// ======================================================================
	// Low slice of b is unsigned, upper slice keeps the sign
	assign pp_lo_d = ax * $signed({1'b0, bx[HALF-1:0]});
	assign pp_hi_d = ax * $signed(bx[XLEN:HALF]);

	// Lines up with the exec result register
	always_ff @(posedge clk)
	begin
		pp_lo_q <= pp_lo_d;
		pp_hi_q <= pp_hi_d;
	end

	// Final add, writeback captures this on the next edge
	assign product = {{(2*XLEN-PP_W){pp_lo_q[PP_W-1]}}, pp_lo_q}
		+ ({{(2*XLEN-PP_W){pp_hi_q[PP_W-1]}}, pp_hi_q} << HALF);

endmodule

// File: logic/alu_decode.sv
/*
 * Decode stage. Splits the instruction, picks the c-or-immediate operand
 * and shift amount, flags illegal encodings and registers the result.
 */
`timescale 1ns/1ps

module alu_decode
	import alu_isa_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             issue_valid,
	input  instr_t           instr,
	input  logic [XLEN-1:0]  a,
	input  logic [XLEN-1:0]  b,
	input  logic [XLEN-1:0]  c,
	input  logic [XLEN-1:0]  t,
	input  logic [TAG_W-1:0] tag,
	alu_op_if.producer       op
);

	logic [XLEN-1:0] imm_sx;
	logic            unimp;
	dec_op_t         dec_d;

	// Sign-extended immediate
	assign imm_sx = {{(XLEN-IMM_W){instr.imm[IMM_W-1]}}, instr.imm};

	// ======================================================================
	// Legal encoding check
	// ======================================================================
	always_comb
	begin
		unimp = 1'b0;
		case (instr.opcode)
			OP_R2:
				case (instr.func)
					// Add also accepts the plus combiner
					FN_ADD:
						unimp = instr.op2 > OP2_ADD;
					FN_AND, FN_OR, FN_EOR:
						unimp = instr.op2 > OP2_EOR;
					FN_SUB, FN_SEQ, FN_SLT, FN_SLTU,
					FN_MIN, FN_MAX, FN_MINU, FN_MAXU:
						unimp = 1'b0;
					default:
						unimp = 1'b1;
				endcase
			OP_SHIFT:
				unimp = instr.func > FN_ASR;
			OP_MUL:
				unimp = instr.func > FN_MULHU;
			OP_CHK:
				unimp = instr.func > CHK_GT_LE;
			OP_ADDI, OP_NOP:
				unimp = 1'b0;
			default:
				unimp = 1'b1;
		endcase
	end

	// ======================================================================
	// Operand selection
	// ======================================================================
	always_comb
	begin
		dec_d.opcode = instr.opcode;
		dec_d.func   = instr.func;
		dec_d.op2    = instr.op2;
		dec_d.a      = a;
		dec_d.b      = b;
		dec_d.t      = t;
		dec_d.tag    = tag;
		// ADDI always adds the immediate
		if (instr.imm_sel || instr.opcode == OP_ADDI)
			dec_d.c = imm_sx;
		else
			dec_d.c = c;
		// Immediate amount or low bits of c
		if (instr.imm_sel)
			dec_d.shamt = instr.shamt[SH_W-1:0];
		else
			dec_d.shamt = c[SH_W-1:0];
		dec_d.chk_code = instr.imm[7:0];
		dec_d.is_unimp = unimp;
		dec_d.is_mul   = (instr.opcode == OP_MUL) && !unimp;
	end

	// Stage boundary onto the operation bus
	alu_stage_reg #(
		.payload_t(dec_op_t)
	) u_dec_reg (
		.clk      (clk),
		.rst      (rst),
		.in_valid (issue_valid),
		.in_data  (dec_d),
		.out_valid(op.valid),
		.out_data (op.data)
	);

endmodule

// File: logic/alu_stage_reg.sv
/*
 * Generic pipeline stage boundary. Valid is cleared by reset,
 * the payload simply follows its input every cycle.
 */
`timescale 1ns/1ps

module alu_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	// Control bit
	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// Payload
	always_ff @(posedge clk)
	begin
		out_data <= in_data;
	end

endmodule

// File: logic/alu_op_if.sv
/*
 * Decoded-operation bundle between decode and the execute stages.
 * One cycle of valid is one operation, there is no ready.
 */
`timescale 1ns/1ps

interface alu_op_if
	import alu_isa_pkg::*;
	();

	// Strobe for this cycle's operation
	logic    valid;
	// Decoded fields and operands
	dec_op_t data;

	// Decode side
	modport producer
	(
		output valid,
		output data
	);

	// Execute and multiplier side
	modport consumer
	(
		input valid,
		input data
	);

endinterface

// File: logic/alu_result_pkg.sv
/*
 * Result-side definitions: fault causes and the execute-stage payload.
 * Import where results are formed or retired.
 */
package alu_result_pkg;

	import alu_isa_pkg::*;

	// Zero means no fault, bounds checks supply their own codes
	typedef enum logic [7:0] {
		CAUSE_NONE  = 8'h00,
		CAUSE_UNIMP = 8'hFE
	} cause_e;

	// Multiplier operand interpretation
	typedef enum logic {
		MUL_SIGNED   = 1'b0,
		MUL_UNSIGNED = 1'b1
	} mul_sel_e;

	// Carried from execute into writeback
	typedef struct packed {
		logic [XLEN-1:0]  value;
		cause_e           cause;
		logic [TAG_W-1:0] tag;
		// Writeback takes the product instead of value
		logic             is_mul;
		// Upper product half wanted
		logic             mul_high;
	} exec_res_t;

endpackage

// File: logic/alu_isa_pkg.sv
/*
 * Instruction set definitions for the three-stage integer execute lane.
 * Import into any block that decodes or executes instructions.
 */
package alu_isa_pkg;

	// ======================================================================
	// Widths
	// ======================================================================
	localparam int XLEN  = 32;
	localparam int TAG_W = 4;
	localparam int IMM_W = 12;
	// Shift amount covers 0 to XLEN-1
	localparam int SH_W  = $clog2(XLEN);

	// Major opcodes, anything else faults as unimplemented
	typedef enum logic [4:0] {
		OP_R2    = 5'd0,
		OP_ADDI  = 5'd1,
		OP_SHIFT = 5'd2,
		OP_CHK   = 5'd3,
		OP_MUL   = 5'd4,
		OP_NOP   = 5'd5
	} opcode_e;

	// Register-register functions under OP_R2
	typedef enum logic [4:0] {
		FN_ADD  = 5'd0,
		FN_SUB  = 5'd1,
		FN_AND  = 5'd2,
		FN_OR   = 5'd3,
		FN_EOR  = 5'd4,
		FN_SEQ  = 5'd5,
		FN_SLT  = 5'd6,
		FN_SLTU = 5'd7,
		FN_MIN  = 5'd8,
		FN_MAX  = 5'd9,
		FN_MINU = 5'd10,
		FN_MAXU = 5'd11
	} func_e;

	// Function field reused by OP_SHIFT
	localparam logic [4:0] FN_ASL = 5'd0;
	localparam logic [4:0] FN_LSR = 5'd1;
	localparam logic [4:0] FN_ASR = 5'd2;

	// Function field reused by OP_MUL, high forms return the upper half
	localparam logic [4:0] FN_MUL   = 5'd0;
	localparam logic [4:0] FN_MULU  = 5'd1;
	localparam logic [4:0] FN_MULH  = 5'd2;
	localparam logic [4:0] FN_MULHU = 5'd3;

	// OP_CHK range forms, a must lie inside the range to pass
	localparam logic [4:0] CHK_GE_LT = 5'd0;
	localparam logic [4:0] CHK_GE_LE = 5'd1;
	localparam logic [4:0] CHK_GT_LT = 5'd2;
	localparam logic [4:0] CHK_GT_LE = 5'd3;

	// op2 combiner applied with the c operand
	localparam logic [2:0] OP2_AND = 3'd0;
	localparam logic [2:0] OP2_OR  = 3'd1;
	localparam logic [2:0] OP2_EOR = 3'd2;
	localparam logic [2:0] OP2_ADD = 3'd3;

	// ======================================================================
	// Instruction word and decoded operation
	// ======================================================================
	typedef struct packed {
		opcode_e          opcode;
		logic [4:0]       func;
		logic [2:0]       op2;
		logic             imm_sel;
		logic [5:0]       shamt;
		logic [IMM_W-1:0] imm;
	} instr_t;

	typedef struct packed {
		opcode_e          opcode;
		logic [4:0]       func;
		logic [2:0]       op2;
		logic [XLEN-1:0]  a;
		logic [XLEN-1:0]  b;
		// c or the sign-extended immediate
		logic [XLEN-1:0]  c;
		logic [XLEN-1:0]  t;
		logic [SH_W-1:0]  shamt;
		// Cause code raised by a failing OP_CHK
		logic [7:0]       chk_code;
		logic [TAG_W-1:0] tag;
		logic             is_mul;
		logic             is_unimp;
	} dec_op_t;

endpackage
